/* fetch_fifo.sv */
/* Fetch FIFO
   Circular buffer of fetched words with their addresses and error flags, flushed in one cycle */
module fetch_fifo
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,

  // Write side, fed by bus responses
  input  logic                push_i,
  input  instr_word_t         push_data_i,
  input  addr_t               push_addr_i,
  input  logic                push_err_i,

  // Read side, the aligner takes the head
  input  logic                pop_i,
  output logic                head_valid_o,
  output instr_word_t         head_data_o,
  output addr_t               head_addr_o,
  output logic                head_err_o,
  output logic [FIFO_PTR_W:0] count_o
);

  instr_word_t           data_q [FIFO_DEPTH];
  addr_t                 addr_q [FIFO_DEPTH];
  logic                  err_q  [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count_q == FIFO_DEPTH);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && head_valid_o;

  // Head entry is visible without a read cycle
  assign head_valid_o = (count_q != '0);
  assign head_data_o  = data_q[rd_ptr_q];
  assign head_addr_o  = addr_q[rd_ptr_q];
  assign head_err_o   = err_q[rd_ptr_q];
  assign count_o      = count_q;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (flush_i)
    begin
      // Flush drops everything, a push in the same cycle too
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push && !flush_i)
    begin
      data_q[wr_ptr_q] <= push_data_i;
      addr_q[wr_ptr_q] <= push_addr_i;
      err_q[wr_ptr_q]  <= push_err_i;
    end
  end

endmodule

/* fetch_pkg.sv */
/* Fetch unit package
   Shared sizes, the address and instruction types, and the two views of a fetched word */
package fetch_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Number of fetched words held between the bus and the aligner
  localparam int unsigned FIFO_DEPTH = 4;

  // Pointer width for the fetch FIFO, the count needs one more bit
  localparam int unsigned FIFO_PTR_W = 2;

  // Largest number of accepted reads still waiting for a response
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Width of the outstanding and discard counters
  localparam int unsigned OUTST_W = 2;

  ////////////////////
  // Types
  ////////////////////

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // One 32-bit instruction, or one word as it comes back from the bus
  typedef logic [31:0] instr_word_t;

  // A fetched word is read either as a whole instruction or as two halfwords
  // The halfword view is what the aligner uses to find compressed instructions
  typedef union packed {
    instr_word_t      word;
    logic [1:0][15:0] half;
  } fetch_word_u;

  // Bus adapter states
  // TRANSPARENT passes the request straight through, REGISTERED replays a held one
  typedef enum logic {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } obi_if_state_e;

endpackage

/* instr_aligner.sv */
/* Instruction aligner
   Cuts fetched words into compressed and 32-bit instructions, also across word boundaries */
module instr_aligner
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,

  // FIFO head
  input  logic        head_valid_i,
  input  instr_word_t head_data_i,
  input  addr_t       head_addr_i,
  input  logic        head_err_i,
  output logic        pop_o,

  // Decode side
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output instr_word_t instr_o,
  output addr_t       instr_addr_o,
  output logic        instr_compressed_o,
  output logic        instr_err_o
);

  fetch_word_u head_w;
  logic        instr_avail;
  logic        consume;
  logic        lo_compressed;
  logic        hi_compressed;
  logic        hold_upper;

  // Offset flag, set when the next instruction starts in the upper halfword
  logic        offset_q;

  // Lower half of a 32-bit instruction that continues in the next word
  logic        held_valid_q;
  logic [15:0] held_half_q;
  addr_t       held_addr_q;
  logic        held_err_q;

  // Full instructions have both low bits set
  function automatic logic is_compressed(logic [15:0] half);
    return (half[1:0] != 2'b11);
  endfunction

  assign head_w.word   = head_data_i;
  assign lo_compressed = is_compressed(head_w.half[0]);
  assign hi_compressed = is_compressed(head_w.half[1]);

  // A 32-bit instruction at offset 2 is parked and its word popped
  // This takes one cycle with no instruction on the output
  assign hold_upper = !held_valid_q && offset_q && head_valid_i && !hi_compressed;

  always_comb
  begin
    instr_avail        = 1'b0;
    instr_o            = head_w.word;
    instr_addr_o       = head_addr_i;
    instr_compressed_o = 1'b0;
    instr_err_o        = head_err_i;
    if (held_valid_q)
    begin
      // Straddling instruction, upper half comes from the new head word
      instr_avail  = head_valid_i;
      instr_o      = {head_w.half[0], held_half_q};
      instr_addr_o = held_addr_q;
      instr_err_o  = held_err_q || head_err_i;
    end
    else if (!offset_q)
    begin
      instr_avail = head_valid_i;
      if (lo_compressed)
      begin
        instr_o            = {16'h0000, head_w.half[0]};
        instr_compressed_o = 1'b1;
      end
    end
    else if (hi_compressed)
    begin
      instr_avail        = head_valid_i;
      instr_o            = {16'h0000, head_w.half[1]};
      instr_addr_o       = head_addr_i + addr_t'(2);
      instr_compressed_o = 1'b1;
    end
  end

  // Nothing leaves in a branch cycle
  assign instr_valid_o = instr_avail && !flush_i;
  assign consume       = instr_valid_o && instr_ready_i;

  // Pop once the last instruction that begins in the head word is gone
  assign pop_o = hold_upper || (consume && !held_valid_q && (offset_q || !lo_compressed));

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      offset_q     <= 1'b0;
      held_valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      // Branch targets are word-aligned
      offset_q     <= 1'b0;
      held_valid_q <= 1'b0;
    end
    else if (hold_upper)
    begin
      offset_q     <= 1'b0;
      held_valid_q <= 1'b1;
    end
    else if (consume)
    begin
      held_valid_q <= 1'b0;
      // After a straddle the next one starts in the upper half of the head
      offset_q     <= held_valid_q || (!offset_q && lo_compressed);
    end
  end

  always_ff @(posedge clk)
  begin
    if (hold_upper)
    begin
      held_half_q <= head_w.half[1];
      held_addr_q <= head_addr_i + addr_t'(2);
      held_err_q  <= head_err_i;
    end
  end

endmodule

/* instr_fetch_assert.sv */
/* Fetch unit bus checks
   Request stability, quiet outputs in reset and the outstanding read limit */
module instr_fetch_assert
  import fetch_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  req_i,
  input logic  gnt_i,
  input addr_t addr_i,
  input logic  rvalid_i,
  input logic  instr_valid_i
);

  // Granted reads still waiting for data
  int unsigned outstanding_q;

  // Assertion failures seen so far
  int unsigned fail_count = 0;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      outstanding_q <= 0;
    end
    else
    begin
      outstanding_q <= outstanding_q + 32'(req_i && gnt_i) - 32'(rvalid_i);
    end
  end

  // An ungranted request stays up with the same address
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
  else
  begin
    $error("Bus request dropped or address changed before its grant");
    fail_count++;
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!req_i && !instr_valid_i))
  else
  begin
    $error("Bus request or instruction valid high during reset");
    fail_count++;
  end

  a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= MAX_OUTSTANDING)
  else
  begin
    $error("More than %0d reads outstanding", MAX_OUTSTANDING);
    fail_count++;
  end

endmodule

bind instr_fetch_top instr_fetch_assert u_fetch_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .req_i         (obi_req_o),
  .gnt_i         (obi_gnt_i),
  .addr_i        (obi_addr_o),
  .rvalid_i      (obi_rvalid_i),
  .instr_valid_i (instr_valid_o)
);

/* instr_fetch_top.sv */
/* Instruction fetch unit
   Prefetch controller, bus adapter, fetch FIFO and aligner wired together */
module instr_fetch_top
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_enable_i,
  input  logic        branch_i,
  input  addr_t       branch_addr_i,

  // OBI instruction bus
  output logic        obi_req_o,
  input  logic        obi_gnt_i,
  output addr_t       obi_addr_o,
  input  logic        obi_rvalid_i,
  input  instr_word_t obi_rdata_i,
  input  logic        obi_err_i,

  // Decode side
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output instr_word_t instr_o,
  output addr_t       instr_addr_o,
  output logic        instr_compressed_o,
  output logic        instr_err_o
);

  // Controller to adapter
  logic                trans_valid;
  logic                trans_ready;
  addr_t               trans_addr;

  // Adapter responses
  logic                resp_valid;
  instr_word_t         resp_rdata;
  logic                resp_err;

  // FIFO write side and fill level
  logic                fifo_push;
  logic                fifo_flush;
  addr_t               push_addr;
  logic                push_err;
  logic [FIFO_PTR_W:0] fifo_count;

  // FIFO head into the aligner
  logic                head_valid;
  instr_word_t         head_data;
  addr_t               head_addr;
  logic                head_err;
  logic                head_pop;

  prefetch_ctrl u_prefetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .trans_valid_o  (trans_valid),
    .trans_ready_i  (trans_ready),
    .trans_addr_o   (trans_addr),
    .resp_valid_i   (resp_valid),
    .resp_err_i     (resp_err),
    .fifo_count_i   (fifo_count),
    .fifo_push_o    (fifo_push),
    .fifo_flush_o   (fifo_flush),
    .push_addr_o    (push_addr),
    .push_err_o     (push_err)
  );

  instr_obi_interface u_instr_obi_interface (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_addr_i  (trans_addr),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .resp_err_o    (resp_err),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_o    (obi_addr_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .obi_err_i     (obi_err_i)
  );

  // Response data goes straight into the FIFO, the controller only tags it
  fetch_fifo u_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (fifo_flush),
    .push_i       (fifo_push),
    .push_data_i  (resp_rdata),
    .push_addr_i  (push_addr),
    .push_err_i   (push_err),
    .pop_i        (head_pop),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .head_addr_o  (head_addr),
    .head_err_o   (head_err),
    .count_o      (fifo_count)
  );

  instr_aligner u_instr_aligner (
    .clk                (clk),
    .rst_n              (rst_n),
    .flush_i            (fifo_flush),
    .head_valid_i       (head_valid),
    .head_data_i        (head_data),
    .head_addr_i        (head_addr),
    .head_err_i         (head_err),
    .pop_o              (head_pop),
    .instr_valid_o      (instr_valid_o),
    .instr_ready_i      (instr_ready_i),
    .instr_o            (instr_o),
    .instr_addr_o       (instr_addr_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_err_o        (instr_err_o)
  );

endmodule

/* instr_obi_interface.sv */
/* Instruction bus adapter
   Holds an ungranted OBI request stable and passes read responses straight through */
module instr_obi_interface
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Request side from the prefetch controller
  input  logic        trans_valid_i,
  output logic        trans_ready_o,
  input  addr_t       trans_addr_i,

  // Response side, the consumer always takes a response in the cycle it appears
  output logic        resp_valid_o,
  output instr_word_t resp_rdata_o,
  output logic        resp_err_o,

  // OBI instruction bus
  output logic        obi_req_o,
  input  logic        obi_gnt_i,
  output addr_t       obi_addr_o,
  input  logic        obi_rvalid_i,
  input  instr_word_t obi_rdata_i,
  input  logic        obi_err_i
);

  obi_if_state_e state_q;
  obi_if_state_e state_d;

  // Address of the request that is waiting for its grant
  addr_t         obi_addr_q;

  ////////////////////
  // Response channel
  ////////////////////

  // Responses come back in order and go on without any added delay
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;
  assign resp_err_o   = obi_err_i;

  ////////////////////
  // Request channel
  ////////////////////

  // Move to REGISTERED when a request is not granted in the cycle it is raised
  // The grant brings the adapter back to TRANSPARENT
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      TRANSPARENT:
      begin
        if (obi_req_o && !obi_gnt_i)
        begin
          state_d = REGISTERED;
        end
      end
      REGISTERED:
      begin
        if (obi_gnt_i)
        begin
          state_d = TRANSPARENT;
        end
      end
      default:
      begin
        state_d = TRANSPARENT;
      end
    endcase
  end

  // In REGISTERED the request stays up and the address comes from the register
  always_comb
  begin
    if (state_q == TRANSPARENT)
    begin
      obi_req_o  = trans_valid_i;
      obi_addr_o = trans_addr_i;
    end
    else
    begin
      obi_req_o  = 1'b1;
      obi_addr_o = obi_addr_q;
    end
  end

  // A new request is taken only when nothing waits for a grant
  // No limit on outstanding reads here, the controller does that
  assign trans_ready_o = (state_q == TRANSPARENT);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= TRANSPARENT;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Capture the address on the step into REGISTERED
  always_ff @(posedge clk)
  begin
    if ((state_q == TRANSPARENT) && (state_d == REGISTERED))
    begin
      obi_addr_q <= trans_addr_i;
    end
  end

endmodule

/* list.f */
fetch_pkg.sv
instr_obi_interface.sv
prefetch_ctrl.sv
fetch_fifo.sv
instr_aligner.sv
instr_fetch_top.sv
instr_fetch_assert.sv
tb_obi_mem.sv
tb_instr_fetch.sv

/* prefetch_ctrl.sv */
/* Prefetch controller
   Issues sequential word reads, bounds outstanding reads and drops stale responses on a branch */
module prefetch_ctrl
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  logic                branch_i,
  input  addr_t               branch_addr_i,

  // Request to the bus adapter
  output logic                trans_valid_o,
  input  logic                trans_ready_i,
  output addr_t               trans_addr_o,

  // Responses from the bus adapter
  input  logic                resp_valid_i,
  input  logic                resp_err_i,

  // Fetch FIFO control
  input  logic [FIFO_PTR_W:0] fifo_count_i,
  output logic                fifo_push_o,
  output logic                fifo_flush_o,
  output addr_t               push_addr_o,
  output logic                push_err_o
);

  logic                enable_q;
  addr_t               fetch_addr_q;
  logic                accept;

  // Issued address queue, one entry per accepted read, in order
  addr_t               tag_q [2**OUTST_W];
  logic [OUTST_W-1:0]  tag_wr_q;
  logic [OUTST_W-1:0]  tag_rd_q;
  logic [OUTST_W-1:0]  outstanding;
  logic [OUTST_W-1:0]  discard_q;
  logic [FIFO_PTR_W:0] occupancy;

  ////////////////////
  // Request side
  ////////////////////

  // Reads in flight are the entries still in the address queue
  assign outstanding = tag_wr_q - tag_rd_q;

  // Words in the FIFO plus reads that may still land there
  assign occupancy = (FIFO_PTR_W + 1)'(outstanding) + fifo_count_i;

  // Nothing is requested in the branch cycle, so every read from before the branch
  // is already counted when the discard counter loads
  assign trans_valid_o = enable_q && !branch_i &&
                         (outstanding < MAX_OUTSTANDING) && (occupancy < FIFO_DEPTH);
  assign accept        = trans_valid_o && trans_ready_i;
  assign trans_addr_o  = fetch_addr_q;

  ////////////////////
  // Response side
  ////////////////////

  // A response is stale while the discard counter is nonzero
  assign fifo_push_o  = resp_valid_i && (discard_q == '0);
  assign fifo_flush_o = branch_i;
  assign push_addr_o  = tag_q[tag_rd_q];
  assign push_err_o   = resp_err_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      enable_q     <= 1'b0;
      fetch_addr_q <= '0;
      tag_wr_q     <= '0;
      tag_rd_q     <= '0;
      discard_q    <= '0;
    end
    else
    begin
      enable_q <= fetch_enable_i;
      // Branch target wins over the sequential step
      if (branch_i)
      begin
        fetch_addr_q <= branch_addr_i;
      end
      else if (accept)
      begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      if (accept)
      begin
        tag_wr_q <= tag_wr_q + 1'b1;
      end
      // Stale responses still pop their queue entry
      if (resp_valid_i)
      begin
        tag_rd_q <= tag_rd_q + 1'b1;
      end
      // Every read in flight that is not answering right now becomes stale
      if (branch_i)
      begin
        discard_q <= outstanding - OUTST_W'(resp_valid_i);
      end
      else if (resp_valid_i && (discard_q != '0))
      begin
        discard_q <= discard_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tag_q[tag_wr_q] <= fetch_addr_q;
    end
  end

endmodule

/* tb_instr_fetch.sv */
/* Fetch unit testbench
   Runs a scenario table and checks each instruction against a walk of the memory image */
module tb_instr_fetch
  import fetch_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        branch;
  addr_t       branch_addr;
  logic        obi_req;
  logic        obi_gnt;
  addr_t       obi_addr;
  logic        obi_rvalid;
  instr_word_t obi_rdata;
  logic        obi_err;
  logic        instr_valid;
  logic        instr_ready;
  instr_word_t instr;
  addr_t       instr_addr;
  logic        instr_compressed;
  logic        instr_err;
  int          errors;
  int          rows_failed;

  // Scenario table with one row per test
  string       row_name   [6];
  addr_t       row_start  [6];
  int unsigned row_count  [6];
  int unsigned row_stall  [6];
  logic        row_branch [6];
  int unsigned row_mix    [6];

  instr_fetch_top UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable),
    .branch_i           (branch),
    .branch_addr_i      (branch_addr),
    .obi_req_o          (obi_req),
    .obi_gnt_i          (obi_gnt),
    .obi_addr_o         (obi_addr),
    .obi_rvalid_i       (obi_rvalid),
    .obi_rdata_i        (obi_rdata),
    .obi_err_i          (obi_err),
    .instr_valid_o      (instr_valid),
    .instr_ready_i      (instr_ready),
    .instr_o            (instr),
    .instr_addr_o       (instr_addr),
    .instr_compressed_o (instr_compressed),
    .instr_err_o        (instr_err)
  );

  tb_obi_mem u_mem (
    .clk          (clk),
    .obi_req_i    (obi_req),
    .obi_gnt_o    (obi_gnt),
    .obi_addr_i   (obi_addr),
    .obi_rvalid_o (obi_rvalid),
    .obi_rdata_o  (obi_rdata),
    .obi_err_o    (obi_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_instr(input string what, input instr_word_t exp, input instr_word_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %b, actual %b", what, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // Memory image and reference walk
  ////////////////////

  // The index sets each halfword and the mix rate decides how many are compressed
  function automatic logic [15:0] fill_half(input logic [12:0] idx, input int unsigned mix);
    logic [31:0] hv;
    logic [15:0] half;
    hv   = (32'(idx) * 32'h9e3779b1) >> 16;
    half = {idx, hv[0], 2'b11};
    if ((hv % 100) < mix)
    begin
      half[1:0] = {1'b0, hv[1]};
    end
    return half;
  endfunction

  task automatic fill_region(input addr_t start, input int unsigned mix);
    logic [12:0] idx;
    for (int i = 0; i < 512; i++)
    begin
      idx = start[13:1] + 13'(i);
      u_mem.mem_h[idx] = fill_half(idx, mix);
    end
  endtask

  // Decode the instruction at pc and flag an error from either word it touches
  task automatic walk_step(input addr_t pc, output instr_word_t exp_instr,
                           output logic exp_comp, output logic exp_err, output addr_t next_pc);
    logic [15:0] lo;
    logic [15:0] hi;
    addr_t       upper;
    upper    = pc + 32'd2;
    lo       = u_mem.mem_h[pc[13:1]];
    hi       = u_mem.mem_h[upper[13:1]];
    exp_comp = (lo[1:0] != 2'b11);
    if (exp_comp)
    begin
      exp_instr = {16'h0000, lo};
      exp_err   = pc[12];
      next_pc   = upper;
    end
    else
    begin
      exp_instr = {hi, lo};
      exp_err   = pc[12] || upper[12];
      next_pc   = pc + 32'd4;
    end
  endtask

  ////////////////////
  // Scenario table
  ////////////////////

  task automatic set_row(input int r, input string name, input addr_t start,
                         input int unsigned count, input int unsigned stall,
                         input logic do_branch, input int unsigned mix);
    row_name[r]   = name;
    row_start[r]  = start;
    row_count[r]  = count;
    row_stall[r]  = stall;
    row_branch[r] = do_branch;
    row_mix[r]    = mix;
  endtask

  // Columns are name, start, instructions, stall percent, mid-run branch, compressed percent
  task automatic load_table();
    set_row(0, "idle",       32'h0000_0000,  0,  0, 1'b0,  0);
    set_row(1, "seq32",      32'h0000_0000, 24,  0, 1'b0,  0);
    set_row(2, "mixed",      32'h0000_0400, 32,  0, 1'b0, 50);
    set_row(3, "branch",     32'h0000_0800, 32,  0, 1'b1, 30);
    set_row(4, "stall",      32'h0000_0c00, 40, 40, 1'b1, 40);
    set_row(5, "err_region", 32'h0000_0fc0, 40, 20, 1'b0, 30);
  endtask

  task automatic run_row(input int r);
    addr_t       pc;
    addr_t       next_pc;
    instr_word_t exp_instr;
    logic        exp_comp;
    logic        exp_err;
    int unsigned got;
    logic        branched;
    int          errs_before;
    string       label;
    errs_before = errors;
    got         = 0;
    if (row_count[r] == 0)
    begin
      // Fetch stays off, so neither the bus nor decode may see anything
      repeat (20)
      begin
        @(negedge clk);
        #1;
        check_flag({row_name[r], " bus request"}, 1'b0, obi_req);
        check_flag({row_name[r], " instr valid"}, 1'b0, instr_valid);
      end
    end
    else
    begin
      // Park the unit, point it at the row start and lay down the program
      @(negedge clk);
      fetch_enable = 1'b0;
      instr_ready  = 1'b0;
      repeat (4) @(negedge clk);
      branch      = 1'b1;
      branch_addr = row_start[r];
      @(negedge clk);
      branch = 1'b0;
      fill_region(row_start[r], row_mix[r]);
      fetch_enable = 1'b1;
      pc           = row_start[r];
      branched     = 1'b0;
      while (got < row_count[r])
      begin
        @(negedge clk);
        branch = 1'b0;
        if (row_branch[r] && !branched && (got == row_count[r] / 2))
        begin
          // Jump while reads are still in flight
          branch      = 1'b1;
          branch_addr = row_start[r] + 32'h100;
          instr_ready = 1'b0;
          branched    = 1'b1;
          pc          = branch_addr;
        end
        else
        begin
          instr_ready = (($urandom % 100) >= row_stall[r]);
        end
        #1;
        if (instr_valid && instr_ready)
        begin
          walk_step(pc, exp_instr, exp_comp, exp_err, next_pc);
          label = $sformatf("%s[%0d]", row_name[r], got);
          check_addr({label, " addr"}, pc, instr_addr);
          check_instr({label, " instr"}, exp_instr, instr);
          check_flag({label, " compressed"}, exp_comp, instr_compressed);
          check_flag({label, " err"}, exp_err, instr_err);
          pc = next_pc;
          got++;
        end
      end
    end
    if (errors != errs_before)
    begin
      rows_failed++;
    end
    $display("Row %s: %0d instructions, %0d errors", row_name[r], got, errors - errs_before);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    void'($urandom(32'h69c9));
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    instr_ready  = 1'b0;
    errors       = 0;
    rows_failed  = 0;
    load_table();
    for (int i = 0; i < 8192; i++)
    begin
      u_mem.mem_h[i] = fill_half(13'(i), 0);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < $size(row_name); r++)
    begin
      run_row(r);
    end
    $display("Rows run %0d, rows failed %0d, errors %0d, assertion failures %0d",
             $size(row_name), rows_failed, errors, UUT.u_fetch_assert.fail_count);
    if ((errors == 0) && (UUT.u_fetch_assert.fail_count == 0))
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // The budget is 40 cycles per table instruction counted from the end of reset
  initial
  begin : watchdog
    int limit;
    int cycles;
    @(posedge rst_n);
    limit  = 0;
    cycles = 0;
    for (int r = 0; r < $size(row_count); r++)
    begin
      limit = limit + 40 * row_count[r];
    end
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run still busy after %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* tb_obi_mem.sv */
/* Instruction bus memory model
   Halfword image with random grant and response delays and an error region at address bit 12 */
module tb_obi_mem
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        obi_req_i,
  output logic        obi_gnt_o,
  input  addr_t       obi_addr_i,
  output logic        obi_rvalid_o,
  output instr_word_t obi_rdata_o,
  output logic        obi_err_o
);

  // 16 KiB image, written directly by the testbench
  logic [15:0] mem_h [8192];

  // Cycles left before the pending request is granted
  int unsigned gnt_wait_q = 0;

  // Granted reads waiting for their response, oldest first
  addr_t       resp_addr [$];
  int unsigned resp_due  [$];
  int unsigned cycle     = 0;
  int unsigned last_due  = 0;

  ////////////////////
  // Grant side
  ////////////////////

  assign obi_gnt_o = obi_req_i && (gnt_wait_q == 0);

  always @(posedge clk)
  begin : grant_side
    int unsigned due;
    if (obi_req_i && obi_gnt_o)
    begin
      // Response 1 to 3 cycles after the grant, never ahead of an older one
      due = cycle + 1 + ($urandom % 3);
      if (due <= last_due)
      begin
        due = last_due + 1;
      end
      last_due = due;
      resp_addr.push_back(obi_addr_i);
      resp_due.push_back(due);
      gnt_wait_q <= $urandom % 4;
    end
    else if (obi_req_i)
    begin
      gnt_wait_q <= gnt_wait_q - 1;
    end
    cycle = cycle + 1;
  end

  ////////////////////
  // Response side
  ////////////////////

  // At most one response per cycle, driven on the falling edge
  initial
  begin : response_side
    addr_t a;
    obi_rvalid_o = 1'b0;
    obi_rdata_o  = '0;
    obi_err_o    = 1'b0;
    forever
    begin
      @(negedge clk);
      obi_rvalid_o = 1'b0;
      obi_err_o    = 1'b0;
      if ((resp_due.size() != 0) && (resp_due[0] <= cycle))
      begin
        a = resp_addr.pop_front();
        void'(resp_due.pop_front());
        obi_rvalid_o = 1'b1;
        obi_rdata_o  = {mem_h[{a[13:2], 1'b1}], mem_h[{a[13:2], 1'b0}]};
        // Data still comes back from the error region, only flagged
        obi_err_o    = a[12];
      end
    end
  end

endmodule
